// File: run.sh
#!/usr/bin/env bash
# build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module dp_tb -o Vdp_tb

out=$(./obj_dir/Vdp_tb 2>&1) || true
echo "$out"

if grep -qxF "TEST RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// File: testbench/dp_checker.sv
// concurrent assertions on the registered dispatch bundle of the rename stage
module dp_checker import dp_pkg::*; (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic [DP_CNT_W-1:0] dp_num_i,
    input logic [DP_CNT_W-1:0] fl_num_i,
    input logic [DP_NUM-1:0]   lane_valid_i,
    input logic                illegal_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // tags are only taken by valid lanes
    fl_within_dp: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fl_num_i <= dp_num_i
    ) else $error("free-list count above dispatch count");

    // valid lanes always form a low-order mask of the count
    valid_is_mask: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        lane_valid_i == DP_NUM'((32'd1 << dp_num_i) - 32'd1)
    ) else $error("lane_valid does not match dispatch count");

    // sampled mid-cycle so the async clear has settled
    quiet_in_reset: assert property (
        @(negedge clk_i)
        !rst_n_i |-> (dp_num_i == '0 && fl_num_i == '0 && lane_valid_i == '0 && !illegal_i)
    ) else $error("control outputs not cleared in reset");

endmodule

// File: testbench/dp_patterns.txt
// inst0 inst1 rob fiq rs fl ftag0 ftag1 | expected dp fl illegal
// then lane 0 and lane 1: rd rs1 rs2 alu opa opb fu tag
003100b3 40628233 2 2 2 2 0a 0b 2 2 0  01 02 03 0 0 0 0 0a  04 05 06 1 0 0 0 0b
00540393 123454b7 2 2 2 2 11 12 2 2 0  07 08 00 0 0 1 0 11  09 00 00 0 2 4 0 12
00001517 008000ef 2 2 2 2 20 21 2 2 0  0a 00 00 0 1 4 0 20  01 00 00 0 1 5 5 21
00008067 00208463 2 2 2 2 30 31 2 0 0  00 01 00 0 0 1 5 00  00 01 02 0 1 3 4 00
00412583 00c1a423 2 2 2 2 05 06 2 1 0  0b 02 00 0 0 1 2 05  00 03 0c 0 0 2 3 00
02f706b3 0328b833 2 2 2 2 3e 3f 2 2 0  0d 0e 0f a 0 0 1 3e  10 11 12 d 0 0 1 3f
300110f3 10500073 2 2 2 2 07 08 2 0 0  00 00 00 0 0 0 6 00  00 00 00 0 0 0 7 00
00000000 003100b3 2 2 2 2 0c 0d 0 0 1  00 00 00 0 0 0 7 00  01 02 03 0 0 0 0 00
00540393 ffffffff 2 2 2 2 15 16 1 1 1  07 08 00 0 0 1 0 15  00 00 00 0 0 0 7 00
023140b3 003100b3 2 2 2 2 18 19 0 0 1  00 00 00 0 0 0 7 00  01 02 03 0 0 0 0 00
003100b3 ffffffff 1 2 2 2 22 23 1 1 0  01 02 03 0 0 0 0 22  00 00 00 0 0 0 7 00
003100b3 40628233 2 2 0 2 2c 2d 0 0 0  01 02 03 0 0 0 0 00  04 05 06 1 0 0 0 00
00310033 40628233 2 2 2 2 2a 2b 2 1 0  00 02 03 0 0 0 0 00  04 05 06 1 0 0 0 2a
003100b3 40628233 3 3 3 3 01 02 2 2 0  01 02 03 0 0 0 0 01  04 05 06 1 0 0 0 02
40335293 009433b3 2 2 2 1 33 34 1 1 0  05 06 00 9 0 1 0 33  07 08 09 3 0 0 0 00
00000000 003100b3 2 0 2 2 26 27 0 0 0  00 00 00 0 0 0 7 00  01 02 03 0 0 0 0 00

// File: testbench/dp_tb.sv
// dispatch testbench with clock, reset, pattern replay, random sweep, checks and watchdog
module dp_tb import dp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // ======================================================================
    // run sizing and row layout
    // ======================================================================
    localparam int CLK_NS  = 40;
    localparam int RST_CYC = 4;
    localparam int NVEC    = 16;
    localparam int NRAND   = 48;
    // inputs, then dp, fl, illegal, then eight fields per lane
    localparam int C_I0 = 0;
    localparam int C_I1 = 1;
    localparam int C_ROB = 2;
    localparam int C_FIQ = 3;
    localparam int C_RS = 4;
    localparam int C_FL = 5;
    localparam int C_FT0 = 6;
    localparam int C_FT1 = 7;
    localparam int C_DP = 8;
    localparam int C_FLN = 9;
    localparam int C_ILL = 10;
    localparam int C_LANE = 11;
    localparam int LANE_W = 8;
    localparam int ROW_W = C_LANE + LANE_W * DP_NUM;
    // two cycles per vector plus reset and slack
    localparam int WATCHDOG_NS = (RST_CYC + 2 * (NVEC + NRAND) + 40) * CLK_NS;
    // wfi encoding, the only word that halts
    localparam logic [31:0] WFI_INST = 32'h1050_0073;
    // fu class code of a lane that goes to no unit
    localparam logic [31:0] FU_NONE_CODE = 32'd7;

    logic                clk = 1'b0;
    logic                rst_n;
    inst_t               inst [DP_NUM];
    logic [DP_CNT_W-1:0] rob_avail;
    logic [DP_CNT_W-1:0] fiq_avail;
    logic [DP_CNT_W-1:0] rs_avail;
    logic [DP_CNT_W-1:0] fl_avail;
    logic [TAG_W-1:0]    fl_tag [DP_NUM];
    logic [DP_CNT_W-1:0] dp_num;
    logic [DP_CNT_W-1:0] fl_num;
    logic [DP_NUM-1:0]   lane_valid;
    logic                illegal;
    dec_lane_t           lane_out [DP_NUM];
    logic [TAG_W-1:0]    tag_out [DP_NUM];

    logic [31:0] pat_mem [NVEC * ROW_W];
    // current vector, directed or random
    logic [31:0] row [ROW_W];
    logic [31:0] rng = 32'he49c;
    int          n_checks = 0;

    always #(CLK_NS / 2) clk = ~clk;

    dp_top dut0 (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .rob_avail_i  (rob_avail),
        .fiq_avail_i  (fiq_avail),
        .rs_avail_i   (rs_avail),
        .fl_avail_i   (fl_avail),
        .fl_tag_i     (fl_tag),
        .dp_num_o     (dp_num),
        .fl_num_o     (fl_num),
        .lane_valid_o (lane_valid),
        .illegal_o    (illegal),
        .lane_o       (lane_out),
        .tag_o        (tag_out)
    );

    bind dp_rename_stage dp_checker u_chk (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dp_num_i     (dp_num_o),
        .fl_num_i     (fl_num_o),
        .lane_valid_i (lane_valid_o),
        .illegal_i    (illegal_o)
    );

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // add rd, x1, x2
    function automatic inst_t add_word(input logic [4:0] rd);
        return {7'h00, 5'd2, 5'd1, 3'b000, rd, 7'h33};
    endfunction

    // addi rd, x1, 1
    function automatic inst_t addi_word(input logic [4:0] rd);
        return {12'h001, 5'd1, 3'b000, rd, 7'h13};
    endfunction

    // drive one row, then read the registered bundle a cycle later
    task automatic play_row();
        int   base;
        logic is_wfi;
        logic exp_ill;
        @(posedge clk);
        inst[0]   <= row[C_I0];
        inst[1]   <= row[C_I1];
        rob_avail <= row[C_ROB][DP_CNT_W-1:0];
        fiq_avail <= row[C_FIQ][DP_CNT_W-1:0];
        rs_avail  <= row[C_RS][DP_CNT_W-1:0];
        fl_avail  <= row[C_FL][DP_CNT_W-1:0];
        fl_tag[0] <= row[C_FT0][TAG_W-1:0];
        fl_tag[1] <= row[C_FT1][TAG_W-1:0];
        // sampled at the next edge, read mid-cycle after it
        @(posedge clk);
        @(negedge clk);
        check_value("dp_num_o", 32'(dp_num), row[C_DP]);
        check_value("fl_num_o", 32'(fl_num), row[C_FLN]);
        check_value("illegal_o", 32'(illegal), row[C_ILL]);
        check_value("lane_valid_o", 32'(lane_valid), (32'd1 << row[C_DP]) - 32'd1);
        for (int k = 0; k < DP_NUM; k++) begin
            base = C_LANE + LANE_W * k;
            // no unit and not wfi means a bad word
            is_wfi  = (row[C_I0 + k] == WFI_INST);
            exp_ill = (row[base + 6] == FU_NONE_CODE) && !is_wfi;
            check_value($sformatf("lane_o[%0d].rd", k), 32'(lane_out[k].rd), row[base]);
            check_value($sformatf("lane_o[%0d].rs1", k), 32'(lane_out[k].rs1), row[base + 1]);
            check_value($sformatf("lane_o[%0d].rs2", k), 32'(lane_out[k].rs2), row[base + 2]);
            check_value($sformatf("lane_o[%0d].alu_func", k), 32'(lane_out[k].alu_func),
                        row[base + 3]);
            check_value($sformatf("lane_o[%0d].opa_sel", k), 32'(lane_out[k].opa_sel),
                        row[base + 4]);
            check_value($sformatf("lane_o[%0d].opb_sel", k), 32'(lane_out[k].opb_sel),
                        row[base + 5]);
            check_value($sformatf("lane_o[%0d].fu_class", k), 32'(lane_out[k].fu_class),
                        row[base + 6]);
            check_value($sformatf("lane_o[%0d].halt", k), 32'(lane_out[k].halt),
                        32'(is_wfi));
            check_value($sformatf("lane_o[%0d].illegal", k), 32'(lane_out[k].illegal),
                        32'(exp_ill));
            check_value($sformatf("tag_o[%0d]", k), 32'(tag_out[k]), row[base + 7]);
        end
    endtask

    // random counts and ADD/ADDI lanes, expected values from the dispatch rules
    task automatic make_random_row();
        logic [31:0] r;
        logic [4:0]  rd;
        logic        is_add;
        int          m;
        int          fl_n;
        int          base;
        rng = xorshift32(rng);
        r = rng;
        row[C_ROB] = 32'(r[1:0]);
        row[C_FIQ] = 32'(r[3:2]);
        row[C_RS]  = 32'(r[5:4]);
        row[C_FL]  = 32'(r[7:6]);
        rng = xorshift32(rng);
        row[C_FT0] = 32'(rng[5:0]);
        row[C_FT1] = 32'(rng[11:6]);
        // smallest free space, never more than the lane count
        m = DP_NUM;
        for (int c = C_ROB; c <= C_FL; c++) begin
            if (row[c] < 32'(m)) begin
                m = int'(row[c]);
            end
        end
        fl_n = 0;
        for (int k = 0; k < DP_NUM; k++) begin
            base   = C_LANE + LANE_W * k;
            rd     = r[8 + 5 * k +: 5];
            is_add = r[18 + k];
            row[C_I0 + k] = is_add ? add_word(rd) : addi_word(rd);
            row[base]     = 32'(rd);
            row[base + 1] = 32'd1;
            row[base + 2] = is_add ? 32'd2 : 32'd0;
            row[base + 3] = 32'd0;
            row[base + 4] = 32'd0;
            row[base + 5] = is_add ? 32'd0 : 32'd1;
            row[base + 6] = 32'd0;
            row[base + 7] = 32'd0;
            // free-list entries in order to valid writers of a real register
            if (k < m && rd != 5'd0) begin
                row[base + 7] = row[C_FT0 + fl_n];
                fl_n++;
            end
        end
        row[C_DP]  = 32'(m);
        row[C_FLN] = 32'(fl_n);
        row[C_ILL] = 32'd0;
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        rst_n     = 1'b0;
        // legal writers and full space, only the reset holds the outputs low
        inst[0]   = add_word(5'd1);
        inst[1]   = add_word(5'd2);
        rob_avail = DP_CNT_W'(DP_NUM);
        fiq_avail = DP_CNT_W'(DP_NUM);
        rs_avail  = DP_CNT_W'(DP_NUM);
        fl_avail  = DP_CNT_W'(DP_NUM);
        fl_tag[0] = '0;
        fl_tag[1] = '0;
        $readmemh("testbench/dp_patterns.txt", pat_mem);

        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("dp_num_o", 32'(dp_num), 32'd0);
        check_value("fl_num_o", 32'(fl_num), 32'd0);
        check_value("lane_valid_o", 32'(lane_valid), 32'd0);
        check_value("illegal_o", 32'(illegal), 32'd0);

        // directed vectors
        for (int v = 0; v < NVEC; v++) begin
            for (int c = 0; c < ROW_W; c++) begin
                row[c] = pat_mem[v * ROW_W + c];
            end
            play_row();
        end

        // random sweep
        for (int v = 0; v < NRAND; v++) begin
            make_random_row();
            play_row();
        end

        if (n_checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("no output checks were executed");
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the run did not complete in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: verilog.f
verilog/dp_pkg.sv
verilog/dp_lane_if.sv
verilog/dp_decoder.sv
verilog/dp_width_ctrl.sv
verilog/dp_rename_stage.sv
verilog/dp_top.sv
testbench/dp_checker.sv
testbench/dp_tb.sv

// File: verilog/dp_decoder.sv
// RV32IM opcode decoder for one dispatch lane with register field masking
module dp_decoder import dp_pkg::*; #(
    parameter int LANE_IDX = 0
) (
    dp_lane_if.dec_mp lane
);

    // ======================================================================
    // fields
    // ======================================================================
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    // register fields the opcode touches, {rd, rs1, rs2}
    logic [2:0] use_regs;
    dec_lane_t  dec;

    assign opcode = lane.inst[6:0];
    assign funct3 = lane.inst[14:12];
    assign funct7 = lane.inst[31:25];

    // catch a decoder placed on a lane that does not exist
    if (LANE_IDX >= DP_NUM) begin : g_idx_check
        $fatal(1, "dp_decoder lane index out of range");
    end

    // integer op from funct3, alt picks SUB or SRA
    function automatic alu_func_e int_func(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  int_func = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  int_func = ALU_SLL;
            F3_SLT:  int_func = ALU_SLT;
            F3_SLTU: int_func = ALU_SLTU;
            F3_XOR:  int_func = ALU_XOR;
            F3_SR:   int_func = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   int_func = ALU_OR;
            default: int_func = ALU_AND;
        endcase
    endfunction

    // ======================================================================
    // opcode table
    // ======================================================================
    always_comb begin
        use_regs     = 3'b000;
        // defaults decode as a NOP on the integer ALU
        dec          = '0;
        dec.alu_func = ALU_ADD;
        dec.opa_sel  = OPA_RS1;
        dec.opb_sel  = OPB_RS2;
        dec.fu_class = FU_ALU;
        case (opcode)
            OPC_LUI: begin
                use_regs    = 3'b100;
                dec.opa_sel = OPA_ZERO;
                dec.opb_sel = OPB_U_IMM;
            end
            OPC_AUIPC: begin
                use_regs    = 3'b100;
                dec.opa_sel = OPA_PC;
                dec.opb_sel = OPB_U_IMM;
            end
            OPC_JAL: begin
                use_regs     = 3'b100;
                dec.opa_sel  = OPA_PC;
                dec.opb_sel  = OPB_J_IMM;
                dec.fu_class = FU_JUMP;
            end
            OPC_JALR: begin
                use_regs     = 3'b110;
                dec.opb_sel  = OPB_I_IMM;
                dec.fu_class = FU_JUMP;
                dec.illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                use_regs     = 3'b011;
                dec.opa_sel  = OPA_PC;
                dec.opb_sel  = OPB_B_IMM;
                dec.fu_class = FU_BRANCH;
                // funct3 010 and 011 are holes in the branch space
                dec.illegal  = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD: begin
                use_regs     = 3'b110;
                dec.opb_sel  = OPB_I_IMM;
                dec.fu_class = FU_LOAD;
                dec.illegal  = !(funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
            end
            OPC_STORE: begin
                use_regs     = 3'b011;
                dec.opb_sel  = OPB_S_IMM;
                dec.fu_class = FU_STORE;
                dec.illegal  = !(funct3 inside {F3_B, F3_H, F3_W});
            end
            OPC_IMM: begin
                use_regs     = 3'b110;
                dec.opb_sel  = OPB_I_IMM;
                dec.alu_func = int_func(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                // shifts leave only the SRAI bit free in the upper immediate
                dec.illegal  = (funct3 == F3_SLL && funct7 != F7_BASE) ||
                               (funct3 == F3_SR && funct7 != F7_BASE && funct7 != F7_ALT);
            end
            OPC_REG: begin
                use_regs = 3'b111;
                if (funct7 == F7_MULDIV) begin
                    dec.fu_class = FU_MULT;
                    case (funct3)
                        F3_MUL:    dec.alu_func = ALU_MUL;
                        F3_MULH:   dec.alu_func = ALU_MULH;
                        F3_MULHSU: dec.alu_func = ALU_MULHSU;
                        F3_MULHU:  dec.alu_func = ALU_MULHU;
                        // divide and remainder have no unit behind dispatch
                        default:   dec.illegal  = 1'b1;
                    endcase
                end else if (funct7 == F7_BASE) begin
                    dec.alu_func = int_func(funct3, 1'b0);
                end else if (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)) begin
                    dec.alu_func = int_func(funct3, 1'b1);
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            OPC_SYSTEM: begin
                if (lane.inst == WFI_WORD) begin
                    dec.halt     = 1'b1;
                    dec.fu_class = FU_NONE;
                end else begin
                    dec.fu_class = FU_CSR;
                    dec.illegal  = !(funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC});
                end
            end
            default: dec.illegal = 1'b1;
        endcase

        // illegal word reads and writes nothing and goes to no unit
        if (dec.illegal) begin
            use_regs     = 3'b000;
            dec.fu_class = FU_NONE;
        end

        // unused fields read as x0
        dec.rd  = use_regs[2] ? lane.inst[11:7] : ZERO_REG;
        dec.rs1 = use_regs[1] ? lane.inst[19:15] : ZERO_REG;
        dec.rs2 = use_regs[0] ? lane.inst[24:20] : ZERO_REG;
    end

    assign lane.dec     = dec;
    assign lane.illegal = dec.illegal;
    assign lane.rd_used = (dec.rd != ZERO_REG);

endmodule

// File: verilog/dp_lane_if.sv
// per-lane decode bundle with decoder and consumer modports
interface dp_lane_if import dp_pkg::*; ();

    // raw word from the fetch queue
    inst_t     inst;
    // decoder result
    dec_lane_t dec;
    logic      illegal;
    // destination is a real register and needs a free-list tag
    logic      rd_used;

    modport dec_mp (
        input  inst,
        output dec,
        output illegal,
        output rd_used
    );

    // count control and rename stage only look
    modport use_mp (
        input inst,
        input dec,
        input illegal,
        input rd_used
    );

endinterface

// File: verilog/dp_pkg.sv
// dispatch widths, RV32IM match constants, decode enums and the decoded-lane struct
package dp_pkg;

    // ======================================================================
    // sizes
    // ======================================================================
    localparam int DP_NUM     = 2;
    // holds a count from 0 to DP_NUM
    localparam int DP_CNT_W   = 2;
    localparam int ARCH_REG_W = 5;
    localparam int TAG_W      = 6;

    // x0 never takes a physical tag
    localparam logic [ARCH_REG_W-1:0] ZERO_REG = '0;

    typedef logic [31:0] inst_t;

    // ======================================================================
    // opcode and funct match values
    // ======================================================================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct7 groups of the register ALU opcode
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // integer ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // multiply funct3, the divide half is not decoded
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    // memory access size
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    localparam inst_t WFI_WORD = 32'h1050_0073;

    // ======================================================================
    // decode result types
    // ======================================================================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] { OPA_RS1, OPA_PC, OPA_ZERO } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
    } opb_sel_e;

    typedef enum logic [2:0] {
        FU_ALU, FU_MULT, FU_LOAD, FU_STORE, FU_BRANCH, FU_JUMP, FU_CSR, FU_NONE
    } fu_class_e;

    // one decoded lane as handed to the reservation stations
    typedef struct packed {
        logic [ARCH_REG_W-1:0] rd;
        logic [ARCH_REG_W-1:0] rs1;
        logic [ARCH_REG_W-1:0] rs2;
        alu_func_e             alu_func;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        fu_class_e             fu_class;
        logic                  halt;
        logic                  illegal;
    } dec_lane_t;

endpackage

// File: verilog/dp_rename_stage.sv
// free-list tag routing and the dispatch to reservation station pipeline register
module dp_rename_stage import dp_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [DP_CNT_W-1:0] dp_cnt_i,
    input  logic                cut_i,
    dp_lane_if.use_mp           lanes [DP_NUM],
    input  logic [TAG_W-1:0]    fl_tag_i [DP_NUM],
    output logic [DP_CNT_W-1:0] dp_num_o,
    output logic [DP_CNT_W-1:0] fl_num_o,
    output logic [DP_NUM-1:0]   lane_valid_o,
    output logic                illegal_o,
    output dec_lane_t           lane_o [DP_NUM],
    output logic [TAG_W-1:0]    tag_o [DP_NUM]
);

    dec_lane_t           lane_dec [DP_NUM];
    logic [DP_NUM-1:0]   lane_rd;
    logic [DP_NUM-1:0]   valid_nxt;
    // running free-list slot, ends as the number of tags taken
    logic [DP_CNT_W-1:0] fl_idx;
    logic [TAG_W-1:0]    tag_nxt [DP_NUM];

    for (genvar k = 0; k < DP_NUM; k++) begin : g_lane
        assign lane_dec[k] = lanes[k].dec;
        assign lane_rd[k]  = lanes[k].rd_used;
    end

    // ======================================================================
    // tag routing
    // ======================================================================
    always_comb begin
        fl_idx = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            valid_nxt[k] = (DP_CNT_W'(k) < dp_cnt_i);
            tag_nxt[k]   = '0;
            // next free-list entry goes to the next writing lane
            if (valid_nxt[k] && lane_rd[k]) begin
                for (int n = 0; n < DP_NUM; n++) begin
                    if (fl_idx == DP_CNT_W'(n)) begin
                        tag_nxt[k] = fl_tag_i[n];
                    end
                end
                fl_idx = fl_idx + 1'b1;
            end
        end
    end

    // ======================================================================
    // output register
    // ======================================================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dp_num_o     <= '0;
            fl_num_o     <= '0;
            lane_valid_o <= '0;
            illegal_o    <= 1'b0;
        end else begin
            dp_num_o     <= dp_cnt_i;
            fl_num_o     <= fl_idx;
            lane_valid_o <= valid_nxt;
            illegal_o    <= cut_i;
        end
    end

    // payload is qualified by lane_valid_o downstream
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < DP_NUM; k++) begin
            lane_o[k] <= lane_dec[k];
            tag_o[k]  <= tag_nxt[k];
        end
    end

endmodule

// File: verilog/dp_top.sv
// two-lane dispatch top with decoders, count control and rename register
module dp_top import dp_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // from the fetch queue
    input  inst_t               inst_i [DP_NUM],
    // free space reported by each consumer
    input  logic [DP_CNT_W-1:0] rob_avail_i,
    input  logic [DP_CNT_W-1:0] fiq_avail_i,
    input  logic [DP_CNT_W-1:0] rs_avail_i,
    input  logic [DP_CNT_W-1:0] fl_avail_i,
    // head of the free list, oldest first
    input  logic [TAG_W-1:0]    fl_tag_i [DP_NUM],
    // registered dispatch bundle
    output logic [DP_CNT_W-1:0] dp_num_o,
    output logic [DP_CNT_W-1:0] fl_num_o,
    output logic [DP_NUM-1:0]   lane_valid_o,
    output logic                illegal_o,
    output dec_lane_t           lane_o [DP_NUM],
    output logic [TAG_W-1:0]    tag_o [DP_NUM]
);

    logic [DP_CNT_W-1:0] dp_cnt;
    logic                cut;

    dp_lane_if lane_if [DP_NUM] ();

    // ======================================================================
    // one decoder per lane
    // ======================================================================
    for (genvar k = 0; k < DP_NUM; k++) begin : g_dec
        assign lane_if[k].inst = inst_i[k];

        dp_decoder #(
            .LANE_IDX (k)
        ) u_dec (
            .lane     (lane_if[k])
        );
    end

    dp_width_ctrl u_width (
        .rob_avail_i (rob_avail_i),
        .fiq_avail_i (fiq_avail_i),
        .rs_avail_i  (rs_avail_i),
        .fl_avail_i  (fl_avail_i),
        .lanes       (lane_if),
        .dp_cnt_o    (dp_cnt),
        .cut_o       (cut)
    );

    dp_rename_stage u_rename (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dp_cnt_i     (dp_cnt),
        .cut_i        (cut),
        .lanes        (lane_if),
        .fl_tag_i     (fl_tag_i),
        .dp_num_o     (dp_num_o),
        .fl_num_o     (fl_num_o),
        .lane_valid_o (lane_valid_o),
        .illegal_o    (illegal_o),
        .lane_o       (lane_o),
        .tag_o        (tag_o)
    );

endmodule

// File: verilog/dp_width_ctrl.sv
// dispatch count comparator tree and truncation at the first illegal lane
module dp_width_ctrl import dp_pkg::*; (
    input  logic [DP_CNT_W-1:0] rob_avail_i,
    input  logic [DP_CNT_W-1:0] fiq_avail_i,
    input  logic [DP_CNT_W-1:0] rs_avail_i,
    input  logic [DP_CNT_W-1:0] fl_avail_i,
    dp_lane_if.use_mp           lanes [DP_NUM],
    output logic [DP_CNT_W-1:0] dp_cnt_o,
    output logic                cut_o
);

    logic [DP_CNT_W-1:0] min_q_rob;
    logic [DP_CNT_W-1:0] min_rs_fl;
    logic [DP_CNT_W-1:0] min_all;
    logic [DP_CNT_W-1:0] avail;
    logic [DP_NUM-1:0]   lane_ill;

    for (genvar k = 0; k < DP_NUM; k++) begin : g_ill
        assign lane_ill[k] = lanes[k].illegal;
    end

    // ======================================================================
    // smallest free space over the four consumers
    // ======================================================================
    assign min_q_rob = (rob_avail_i < fiq_avail_i) ? rob_avail_i : fiq_avail_i;
    assign min_rs_fl = (rs_avail_i < fl_avail_i) ? rs_avail_i : fl_avail_i;
    assign min_all   = (min_q_rob < min_rs_fl) ? min_q_rob : min_rs_fl;
    // a count of 3 fits the field but there are only two lanes
    assign avail     = (min_all > DP_CNT_W'(DP_NUM)) ? DP_CNT_W'(DP_NUM) : min_all;

    // stop in front of the lowest illegal lane inside the window
    always_comb begin
        dp_cnt_o = avail;
        cut_o    = 1'b0;
        // walk downwards so the lowest hit wins
        for (int k = DP_NUM - 1; k >= 0; k--) begin
            if ((DP_CNT_W'(k) < avail) && lane_ill[k]) begin
                dp_cnt_o = DP_CNT_W'(k);
                cut_o    = 1'b1;
            end
        end
    end

endmodule
